// ==== include/scene_loader_params.svh ====
`ifndef SCENE_LOADER_PARAMS_SVH
`define SCENE_LOADER_PARAMS_SVH

// uart bit time in system clocks.
`define SCENE_CLKS_PER_BIT 8

// scene geometry.
`define SCENE_NUM_OBJS     16
`define SCENE_OBJ_IDX_W    4
`define SCENE_OBJ_W        64 // 8 payload bytes.
`define SCENE_CAM_W        72 // three 24-bit components.
`define SCENE_NUM_CAM_VECS 4  // origin, right, forward, up.

// wishbone bus and word map.
`define SCENE_WB_ADR_W        6
`define SCENE_WB_DAT_W        32
`define SCENE_ADR_CAM_BASE    0
`define SCENE_ADR_NUM_OBJS    12
`define SCENE_ADR_MAX_BOUNCES 13
`define SCENE_ADR_OBJ_BASE    32

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the scene loader testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f scene_loader.f \
  --top-module scene_loader_tb \
  -Mdir obj_dir -o scene_loader_sim > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$build_log"
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/scene_loader_sim > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" "$sim_log"; then
  exit 1
fi
exit 0

// ==== scene_loader.f ====
+incdir+include
source/scene_pkg.sv
source/uart_rx.sv
source/scene_cmd_decoder.sv
source/scene_store.sv
source/scene_loader_top.sv
test/scene_loader_assert.sv
test/scene_loader_tb.sv

// ==== source/scene_cmd_decoder.sv ====
`default_nettype none

`include "scene_loader_params.svh"

module scene_cmd_decoder (
  input  wire                     clk,
  input  wire                     rst,
  input  wire scene_pkg::byte_t   rx_byte,
  input  wire                     rx_valid,
  output logic                    busy,
  output logic                    load_en,
  output scene_pkg::load_target_t load_target,
  output scene_pkg::obj_idx_t     load_index,
  output scene_pkg::payload_t     load_data
);

  localparam int CAM_BYTES = `SCENE_CAM_W / 8;
  localparam int OBJ_BYTES = `SCENE_OBJ_W / 8;
  localparam int CNT_W     = $clog2(CAM_BYTES + 1);

  typedef enum logic {
    idle,
    payload
  } dec_state_t;

  dec_state_t       state;
  logic [CNT_W-1:0] byte_idx;  // position of the next payload byte.
  logic [CNT_W-1:0] byte_last; // position of the final byte for this target.

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= idle;
      busy     <= 1'b0;
      load_en  <= 1'b0;
      byte_idx <= '0;
    end else begin
      load_en <= 1'b0;
      case (state)
        idle: begin
          if (load_en) busy <= 1'b0; // drop one cycle after the commit.
          if (rx_valid) begin
            byte_idx  <= '0;
            load_data <= '0; // short payloads read as zero above their bytes.
            casez (rx_byte)
              8'b0???????: begin
                state       <= payload;
                busy        <= 1'b1;
                load_target <= scene_pkg::tgt_obj;
                load_index  <= rx_byte[`SCENE_OBJ_IDX_W-1:0];
                byte_last   <= CNT_W'(OBJ_BYTES - 1);
              end
              8'b1????0??: begin
                state       <= payload;
                busy        <= 1'b1;
                load_target <= scene_pkg::tgt_cam;
                load_index  <= scene_pkg::obj_idx_t'(rx_byte[1:0]); // camera selector.
                byte_last   <= CNT_W'(CAM_BYTES - 1);
              end
              8'b1????100: begin
                state       <= payload;
                busy        <= 1'b1;
                load_target <= scene_pkg::tgt_num_objs;
                load_index  <= '0;
                byte_last   <= '0;
              end
              8'b1????101: begin
                state       <= payload;
                busy        <= 1'b1;
                load_target <= scene_pkg::tgt_max_bounces;
                load_index  <= '0;
                byte_last   <= '0;
              end
              // 1xxxx11x is not a command, stay idle.
              default: state <= idle;
            endcase
          end
        end
        payload: begin
          if (rx_valid) begin
            load_data[{byte_idx, 3'b000} +: 8] <= rx_byte;
            byte_idx <= byte_idx + 1'b1;
            if (byte_idx == byte_last) begin
              load_en <= 1'b1;
              state   <= idle;
            end
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/scene_loader_top.sv ====
`default_nettype none

module scene_loader_top (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     uart_rx_line,
  output logic                    loader_busy,
  input  wire                     wb_cyc,
  input  wire                     wb_stb,
  input  wire                     wb_we,
  input  wire scene_pkg::wb_adr_t wb_adr,
  input  wire scene_pkg::wb_dat_t wb_dat_w,
  output logic                    wb_ack,
  output scene_pkg::wb_dat_t      wb_dat_r
);

  scene_pkg::byte_t        rx_byte;
  logic                    rx_valid;
  logic                    load_en;
  scene_pkg::load_target_t load_target;
  scene_pkg::obj_idx_t     load_index;
  scene_pkg::payload_t     load_data;

  // serial line to bytes.
  uart_rx i_uart_rx (
    .clk      (clk),
    .rst      (rst),
    .rx_line  (uart_rx_line),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

  // bytes to load commands.
  scene_cmd_decoder i_scene_cmd_decoder (
    .clk         (clk),
    .rst         (rst),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .busy        (loader_busy),
    .load_en     (load_en),
    .load_target (load_target),
    .load_index  (load_index),
    .load_data   (load_data)
  );

  scene_store i_scene_store (
    .clk         (clk),
    .rst         (rst),
    .load_en     (load_en),
    .load_target (load_target),
    .load_index  (load_index),
    .load_data   (load_data),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_ack      (wb_ack),
    .wb_dat_r    (wb_dat_r)
  );

endmodule

`default_nettype wire

// ==== source/scene_pkg.sv ====
`default_nettype none

`include "scene_loader_params.svh"

package scene_pkg;

  typedef logic [7:0] byte_t; // one uart byte.

  typedef logic [`SCENE_CAM_W-1:0]     cam_vec_t;
  typedef logic [`SCENE_OBJ_W-1:0]     obj_t;
  typedef logic [`SCENE_OBJ_IDX_W-1:0] obj_idx_t;

  // widest target sets the payload width, byte 0 sits at bit 0.
  typedef logic [`SCENE_CAM_W-1:0] payload_t;

  typedef enum logic [1:0] {
    tgt_cam,
    tgt_obj,
    tgt_num_objs,
    tgt_max_bounces
  } load_target_t;

  typedef logic [`SCENE_WB_ADR_W-1:0] wb_adr_t;
  typedef logic [`SCENE_WB_DAT_W-1:0] wb_dat_t;

endpackage

`default_nettype wire

// ==== source/scene_store.sv ====
`default_nettype none

`include "scene_loader_params.svh"

module scene_store (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          load_en,
  input  wire scene_pkg::load_target_t load_target,
  input  wire scene_pkg::obj_idx_t     load_index,
  input  wire scene_pkg::payload_t     load_data,
  input  wire                          wb_cyc,
  input  wire                          wb_stb,
  input  wire                          wb_we,
  input  wire scene_pkg::wb_adr_t      wb_adr,
  input  wire scene_pkg::wb_dat_t      wb_dat_w,
  output logic                         wb_ack,
  output scene_pkg::wb_dat_t           wb_dat_r
);

  localparam int CAM_COMPS  = 3;
  localparam int CAM_COMP_W = `SCENE_CAM_W / CAM_COMPS;

  scene_pkg::cam_vec_t cam [`SCENE_NUM_CAM_VECS];
  scene_pkg::obj_t     objs [`SCENE_NUM_OBJS];
  scene_pkg::byte_t    num_objs;
  scene_pkg::byte_t    max_bounces;

  scene_pkg::wb_adr_t  obj_off;  // word offset into the object region.
  scene_pkg::wb_dat_t  rd_word;
  logic [`SCENE_WB_ADR_W-2:0] obj_slot;

  // load side.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int v = 0; v < `SCENE_NUM_CAM_VECS; v++) begin
        cam[v] <= '0;
      end
      for (int i = 0; i < `SCENE_NUM_OBJS; i++) begin
        objs[i] <= '0;
      end
      num_objs    <= '0;
      max_bounces <= '0;
    end else if (load_en) begin
      case (load_target)
        scene_pkg::tgt_cam:
          cam[load_index[1:0]] <= load_data;
        scene_pkg::tgt_obj:
          objs[load_index] <= load_data[`SCENE_OBJ_W-1:0];
        scene_pkg::tgt_num_objs:
          num_objs <= load_data[7:0];
        scene_pkg::tgt_max_bounces:
          max_bounces <= load_data[7:0];
        default: ;
      endcase
    end
  end

  // word decode for the read port.
  always_comb begin
    rd_word  = '0;
    obj_off  = wb_adr - scene_pkg::wb_adr_t'(`SCENE_ADR_OBJ_BASE);
    obj_slot = obj_off[`SCENE_WB_ADR_W-1:1]; // two words per object.

    for (int v = 0; v < `SCENE_NUM_CAM_VECS; v++) begin
      for (int c = 0; c < CAM_COMPS; c++) begin
        if (wb_adr == scene_pkg::wb_adr_t'(`SCENE_ADR_CAM_BASE + v * CAM_COMPS + c)) begin
          rd_word = scene_pkg::wb_dat_t'(cam[v][c * CAM_COMP_W +: CAM_COMP_W]);
        end
      end
    end

    if (wb_adr == scene_pkg::wb_adr_t'(`SCENE_ADR_NUM_OBJS)) begin
      rd_word = scene_pkg::wb_dat_t'(num_objs);
    end
    if (wb_adr == scene_pkg::wb_adr_t'(`SCENE_ADR_MAX_BOUNCES)) begin
      rd_word = scene_pkg::wb_dat_t'(max_bounces);
    end

    if (wb_adr >= scene_pkg::wb_adr_t'(`SCENE_ADR_OBJ_BASE) && obj_slot < `SCENE_NUM_OBJS) begin
      if (obj_off[0]) begin
        rd_word = objs[obj_slot[`SCENE_OBJ_IDX_W-1:0]][`SCENE_OBJ_W-1:`SCENE_WB_DAT_W];
      end else begin
        rd_word = objs[obj_slot[`SCENE_OBJ_IDX_W-1:0]][`SCENE_WB_DAT_W-1:0];
      end
    end
  end

  // classic slave, one wait state. writes are acked and discard wb_dat_w.
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_cyc && wb_stb && !wb_ack; // never two acks back to back.
    end
  end

  always_ff @(posedge clk) begin
    wb_dat_r <= wb_we ? '0 : rd_word;
  end

endmodule

`default_nettype wire

// ==== source/uart_rx.sv ====
`default_nettype none

`include "scene_loader_params.svh"

module uart_rx (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    rx_line,
  output scene_pkg::byte_t       rx_byte,
  output logic                   rx_valid
);

  localparam int CNT_W    = $clog2(`SCENE_CLKS_PER_BIT + 1);
  localparam int HALF_BIT = `SCENE_CLKS_PER_BIT / 2;

  typedef enum logic [1:0] {
    idle,
    start,
    data,
    stop
  } rx_state_t;

  rx_state_t        state;
  logic             rx_meta;
  logic             rx_sync;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  scene_pkg::byte_t shreg;

  // two-flop synchronizer, line idles high.
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx_line;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= idle;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0; // single-cycle pulse.
      clk_cnt  <= clk_cnt + 1'b1;
      case (state)
        idle: begin
          clk_cnt <= '0;
          if (!rx_sync) state <= start; // falling edge of start bit.
        end
        start: begin
          if (clk_cnt == CNT_W'(HALF_BIT - 1)) begin
            clk_cnt <= '0;
            // still low at mid-bit, otherwise a glitch.
            state   <= rx_sync ? idle : data;
            bit_idx <= '0;
          end
        end
        data: begin
          if (clk_cnt == CNT_W'(`SCENE_CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            shreg   <= {rx_sync, shreg[7:1]}; // lsb arrives first.
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= stop;
          end
        end
        stop: begin
          if (clk_cnt == CNT_W'(`SCENE_CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            state   <= idle;
            if (rx_sync) begin
              rx_byte  <= shreg;
              rx_valid <= 1'b1;
            end
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== test/scene_loader_assert.sv ====
`default_nettype none

module scene_loader_assert (
  input wire clk,
  input wire rst,
  input wire wb_cyc,
  input wire wb_stb,
  input wire wb_ack,
  input wire load_en,
  input wire loader_busy
);

  // an ack only answers a live request.
  ack_with_request: assert property (
    @(posedge clk) disable iff (rst) wb_ack |-> (wb_cyc && wb_stb)
  ) else $error("wb_ack high without wb_cyc and wb_stb");

  ack_single_cycle: assert property (
    @(posedge clk) disable iff (rst) wb_ack |=> !wb_ack
  ) else $error("wb_ack high on two consecutive cycles");

  load_single_cycle: assert property (
    @(posedge clk) disable iff (rst) load_en |=> !load_en
  ) else $error("load_en longer than one cycle");

  // checked through the whole reset, not only its last cycle.
  busy_low_after_reset: assert property (
    @(posedge clk) rst |=> !loader_busy
  ) else $error("loader_busy high after reset");

endmodule

bind scene_loader_top scene_loader_assert i_scene_loader_assert (
  .clk         (clk),
  .rst         (rst),
  .wb_cyc      (wb_cyc),
  .wb_stb      (wb_stb),
  .wb_ack      (wb_ack),
  .load_en     (load_en),
  .loader_busy (loader_busy)
);

`default_nettype wire

// ==== test/scene_loader_tb.sv ====
`default_nettype none

`include "scene_loader_params.svh"

module scene_loader_tb;

  localparam int CLK_PERIOD  = 40;
  localparam int FRAME_BITS  = 10;  // start, eight data bits, stop.
  localparam int CAM_BYTES   = `SCENE_CAM_W / 8;
  localparam int OBJ_BYTES   = `SCENE_OBJ_W / 8;
  localparam int COMP_W      = `SCENE_CAM_W / 3;
  localparam int NUM_WORDS   = 1 << `SCENE_WB_ADR_W;
  localparam int TOTAL_BYTES = 101; // uart bytes sent by all tests.
  localparam int READ_CYCLES = 6 * NUM_WORDS * 4; // six full readbacks.
  localparam longint WATCHDOG_CYCLES =
    longint'(TOTAL_BYTES) * FRAME_BITS * `SCENE_CLKS_PER_BIT + READ_CYCLES + 600;

  logic               clk;
  logic               rst;
  logic               uart_rx_line;
  logic               loader_busy;
  logic               wb_cyc;
  logic               wb_stb;
  logic               wb_we;
  scene_pkg::wb_adr_t wb_adr;
  scene_pkg::wb_dat_t wb_dat_w;
  logic               wb_ack;
  scene_pkg::wb_dat_t wb_dat_r;

  // scene model, written once a command is fully sent.
  logic [`SCENE_CAM_W-1:0] cam_m [`SCENE_NUM_CAM_VECS];
  logic [`SCENE_OBJ_W-1:0] obj_m [`SCENE_NUM_OBJS];
  logic [7:0]              num_objs_m;
  logic [7:0]              bounces_m;

  integer seed;
  int     errors;
  int     checks;
  int     tests_run;
  int     tests_failed;
  int     errors_at_start;
  string  test_name;
  event   check_req;
  event   check_done;

  scene_loader_top i_scene_loader_top (
    .clk          (clk),
    .rst          (rst),
    .uart_rx_line (uart_rx_line),
    .loader_busy  (loader_busy),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_ack       (wb_ack),
    .wb_dat_r     (wb_dat_r)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // word at any bus address, from the model and the address map.
  function automatic logic [31:0] expected_word(input int adr);
    int rel;
    expected_word = '0;
    rel = adr - `SCENE_ADR_OBJ_BASE;
    if (adr >= `SCENE_ADR_CAM_BASE && adr < `SCENE_ADR_CAM_BASE + 3 * `SCENE_NUM_CAM_VECS) begin
      rel = adr - `SCENE_ADR_CAM_BASE;
      expected_word = 32'(cam_m[rel / 3][(rel % 3) * COMP_W +: COMP_W]);
    end else if (adr == `SCENE_ADR_NUM_OBJS) begin
      expected_word = {24'h0, num_objs_m};
    end else if (adr == `SCENE_ADR_MAX_BOUNCES) begin
      expected_word = {24'h0, bounces_m};
    end else if (rel >= 0 && rel < 2 * `SCENE_NUM_OBJS) begin
      expected_word = obj_m[rel / 2][(rel % 2) * 32 +: 32]; // low word first.
    end
  endfunction

  task automatic random_payload(input int n, output logic [`SCENE_CAM_W-1:0] data);
    data = '0;
    for (int i = 0; i < n; i++) begin
      data[i * 8 +: 8] = 8'($random(seed));
    end
  endtask

  // one 8n1 frame, lsb first.
  task automatic send_byte(input logic [7:0] b);
    logic [FRAME_BITS-1:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < FRAME_BITS; i++) begin
      @(posedge clk);
      uart_rx_line <= frame[i];
      repeat (`SCENE_CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  task automatic wait_loader_idle();
    int n;
    n = 0;
    @(negedge clk);
    while (loader_busy && n < 64) begin
      @(negedge clk);
      n++;
    end
    if (loader_busy) begin
      $display("loader still busy %0d cycles after the last payload byte", n);
      errors++;
    end
  endtask

  task automatic send_command(input logic [7:0] cmd, input logic [`SCENE_CAM_W-1:0] data,
                              input int n);
    send_byte(cmd);
    for (int i = 0; i < n; i++) begin
      send_byte(data[i * 8 +: 8]);
    end
    wait_loader_idle();
  endtask

  // classic cycle, held until ack and dropped the cycle after.
  task automatic wb_cycle(input logic we, input int adr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic acked);
    int n;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= scene_pkg::wb_adr_t'(adr);
    wb_dat_w <= wdata;
    acked = 1'b0;
    n = 0;
    while (!acked && n < 16) begin
      @(negedge clk);
      acked = wb_ack;
      n++;
    end
    rdata = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    if (!acked) begin
      $display("no wishbone acknowledge for %s at address 0x%02h", we ? "write" : "read", adr);
      errors++;
    end
  endtask

  // reads back the whole map when a test asks for it.
  always begin : compare_scene
    logic [31:0] got;
    logic [31:0] exp;
    logic        acked;
    @(check_req);
    for (int a = 0; a < NUM_WORDS; a++) begin
      wb_cycle(1'b0, a, 32'h0, got, acked);
      exp = expected_word(a);
      checks++;
      if (acked && got !== exp) begin
        $display("error: wb_dat_r at address 0x%02h expected 0x%08h got 0x%08h", a, exp, got);
        errors++;
      end
    end
    -> check_done;
  end

  task automatic begin_test(input string name);
    test_name = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    -> check_req;
    @(check_done);
    tests_run++;
    if (errors != errors_at_start) begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, test_name, errors - errors_at_start);
    end else begin
      $display("test %0d %s: ok", tests_run, test_name);
    end
  endtask

  initial begin : main_sequence
    logic [`SCENE_CAM_W-1:0] data;
    logic [31:0]             rdata;
    logic                    acked;
    int                      idx;
    seed = 32'hf015_53e9;
    rst = 1'b1;
    uart_rx_line = 1'b1; // idle line.
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    for (int v = 0; v < `SCENE_NUM_CAM_VECS; v++) begin
      cam_m[v] = '0;
    end
    for (int i = 0; i < `SCENE_NUM_OBJS; i++) begin
      obj_m[i] = '0;
    end
    num_objs_m = '0;
    bounces_m = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    begin_test("reset state");
    @(negedge clk);
    if (loader_busy !== 1'b0) begin
      $display("error: loader_busy expected 0x0 got 0x%h", loader_busy);
      errors++;
    end
    end_test();

    begin_test("camera vectors");
    for (int v = 0; v < `SCENE_NUM_CAM_VECS; v++) begin
      random_payload(CAM_BYTES, data);
      send_command({1'b1, 4'b1010, 1'b0, 2'(v)}, data, CAM_BYTES);
      cam_m[v] = data;
    end
    end_test();

    begin_test("object loads");
    for (int k = 0; k < 5; k++) begin
      if (k == 0 || k == 4) idx = 0; // last pass reloads slot 0.
      else if (k == 1) idx = `SCENE_NUM_OBJS - 1;
      else idx = $random(seed) & (`SCENE_NUM_OBJS - 1);
      random_payload(OBJ_BYTES, data);
      send_command({1'b0, 3'b101, scene_pkg::obj_idx_t'(idx)}, data, OBJ_BYTES);
      obj_m[idx] = data[`SCENE_OBJ_W-1:0];
    end
    end_test();

    begin_test("object count and bounces");
    random_payload(1, data);
    send_command(8'h84, data, 1);
    num_objs_m = data[7:0];
    random_payload(1, data);
    send_command(8'hbd, data, 1);
    bounces_m = data[7:0];
    end_test();

    begin_test("unknown commands");
    send_byte(8'hfe);
    send_byte(8'h87);
    repeat (4) @(negedge clk);
    if (loader_busy !== 1'b0) begin
      $display("loader went busy on an unknown command byte");
      errors++;
    end
    random_payload(CAM_BYTES, data);
    send_command(8'h81, data, CAM_BYTES);
    cam_m[1] = data;
    end_test();

    begin_test("wishbone writes");
    wb_cycle(1'b1, `SCENE_ADR_NUM_OBJS, 32'hdead_beef, rdata, acked);
    wb_cycle(1'b1, `SCENE_ADR_OBJ_BASE + 1, 32'h1234_5678, rdata, acked);
    wb_cycle(1'b1, 20, 32'hffff_ffff, rdata, acked); // unmapped word.
    end_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire
